/* Makefile */
# Verilator build and run of the multiply/divide unit testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, log to sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module muldiv_tb -Mdir obj_dir
	./obj_dir/Vmuldiv_tb > sim.log 2>&1 || echo "SOME TESTS FAILED" >> sim.log
	@cat sim.log
	@! grep -q "SOME TESTS FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

/* project.f */
source/muldiv_pkg.sv
source/muldiv_intf.sv
source/muldiv_decode.sv
source/muldiv_iterate.sv
source/muldiv_result.sv
source/muldiv_unit.sv
verification/muldiv_checker.sv
verification/muldiv_tb.sv

/* source/muldiv_decode.sv */
/*
 * Multiply/divide decode stage
 * Captures the op from D, turns operands into magnitudes, flags sign
 * fix-up and divide by zero for the later stages
 */

`timescale 1ns/1ps
`default_nettype none

module muldiv_decode #(
  parameter int seq_bits = muldiv_pkg::SEQ_BITS_DEFAULT
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              d_val,
  input  logic [muldiv_pkg::XLEN-1:0]       d_pc,
  input  logic [seq_bits-1:0]               d_seq_num,
  input  logic [muldiv_pkg::XLEN-1:0]       d_op1,
  input  logic [muldiv_pkg::XLEN-1:0]       d_op2,
  input  logic [muldiv_pkg::ADDR_BITS-1:0]  d_waddr,
  input  muldiv_pkg::muldiv_uop_e           d_uop,
  output logic                              d_rdy,
  op_intf.decode                            op
);

  logic                        signed_a;
  logic                        signed_b;
  logic                        sign_a;
  logic                        sign_b;
  logic                        is_div_c;
  muldiv_pkg::res_sel_e        res_sel_c;
  logic [muldiv_pkg::XLEN-1:0] mag_a_c;
  logic [muldiv_pkg::XLEN-1:0] mag_b_c;
  logic                        d_xfer;

  // --------------------
  // Op classification
  // --------------------

  always_comb begin
    signed_a  = 1'b0;
    signed_b  = 1'b0;
    is_div_c  = 1'b0;
    res_sel_c = muldiv_pkg::PROD_LO;
    case (d_uop)
      muldiv_pkg::UOP_MULH: begin
        signed_a  = 1'b1;
        signed_b  = 1'b1;
        res_sel_c = muldiv_pkg::PROD_HI;
      end
      // Only op1 signed here
      muldiv_pkg::UOP_MULHSU: begin
        signed_a  = 1'b1;
        res_sel_c = muldiv_pkg::PROD_HI;
      end
      muldiv_pkg::UOP_MULHU: begin
        res_sel_c = muldiv_pkg::PROD_HI;
      end
      muldiv_pkg::UOP_DIV: begin
        signed_a  = 1'b1;
        signed_b  = 1'b1;
        is_div_c  = 1'b1;
        res_sel_c = muldiv_pkg::QUOT;
      end
      muldiv_pkg::UOP_DIVU: begin
        is_div_c  = 1'b1;
        res_sel_c = muldiv_pkg::QUOT;
      end
      muldiv_pkg::UOP_REM: begin
        signed_a  = 1'b1;
        signed_b  = 1'b1;
        is_div_c  = 1'b1;
        res_sel_c = muldiv_pkg::REM;
      end
      muldiv_pkg::UOP_REMU: begin
        is_div_c  = 1'b1;
        res_sel_c = muldiv_pkg::REM;
      end
      // MUL low word is the same for any signedness
      default: begin
        res_sel_c = muldiv_pkg::PROD_LO;
      end
    endcase
  end

  // Operand signs and magnitudes
  assign sign_a  = signed_a & d_op1[muldiv_pkg::XLEN-1];
  assign sign_b  = signed_b & d_op2[muldiv_pkg::XLEN-1];
  assign mag_a_c = sign_a ? -d_op1 : d_op1;
  assign mag_b_c = sign_b ? -d_op2 : d_op2;

  // --------------------
  // Op register
  // --------------------

  // Free slot, or the engine drains it this cycle
  assign d_rdy  = !op.val || op.rdy;
  assign d_xfer = d_val && d_rdy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      op.val <= 1'b0;
    end else if (d_xfer) begin
      op.val <= 1'b1;
    end else if (op.rdy) begin
      op.val <= 1'b0;
    end
  end

  // Payload, no reset
  always_ff @(posedge clk) begin
    if (d_xfer) begin
      op.pc         <= d_pc;
      op.seq_num    <= d_seq_num;
      op.waddr      <= d_waddr;
      op.mag_a      <= mag_a_c;
      op.mag_b      <= mag_b_c;
      op.is_div     <= is_div_c;
      op.res_sel    <= res_sel_c;
      op.neg_result <= sign_a ^ sign_b;
      // Remainder follows the dividend
      op.neg_rem    <= is_div_c & sign_a;
      op.div_zero   <= is_div_c && (d_op2 == '0);
    end
  end

  // Valid op must carry a known encoding
  uop_known_a: assert property (@(posedge clk) disable iff (!rst_n)
    d_val |-> !$isunknown(d_uop))
    else $error("d_uop unknown while d_val high");

endmodule

`default_nettype wire

/* source/muldiv_intf.sv */
/*
 * Internal stream interfaces of the multiply/divide unit
 * op_intf carries decoded ops to the engine, res_intf raw results out
 */

`timescale 1ns/1ps
`default_nettype none

// --------------------
// Decode to iterate
// --------------------

interface op_intf #(
  parameter int seq_bits = muldiv_pkg::SEQ_BITS_DEFAULT
);

  logic                                val;
  logic                                rdy;
  logic [muldiv_pkg::XLEN-1:0]         pc;
  logic [seq_bits-1:0]                 seq_num;
  logic [muldiv_pkg::ADDR_BITS-1:0]    waddr;
  // Unsigned operand magnitudes
  logic [muldiv_pkg::XLEN-1:0]         mag_a;
  logic [muldiv_pkg::XLEN-1:0]         mag_b;
  logic                                is_div;
  muldiv_pkg::res_sel_e                res_sel;
  // Sign fix-up flags for the result stage
  logic                                neg_result;
  logic                                neg_rem;
  logic                                div_zero;

  modport decode (
    output val, pc, seq_num, waddr, mag_a, mag_b, is_div, res_sel,
    output neg_result, neg_rem, div_zero,
    input  rdy
  );

  modport iterate (
    input  val, pc, seq_num, waddr, mag_a, mag_b, is_div, res_sel,
    input  neg_result, neg_rem, div_zero,
    output rdy
  );

endinterface

// --------------------
// Iterate to result
// --------------------

interface res_intf #(
  parameter int seq_bits = muldiv_pkg::SEQ_BITS_DEFAULT
);

  logic                                val;
  logic                                rdy;
  logic [muldiv_pkg::XLEN-1:0]         pc;
  logic [seq_bits-1:0]                 seq_num;
  logic [muldiv_pkg::ADDR_BITS-1:0]    waddr;
  // Product high/low, or remainder/quotient for a divide
  logic [muldiv_pkg::XLEN-1:0]         raw_hi;
  logic [muldiv_pkg::XLEN-1:0]         raw_lo;
  muldiv_pkg::res_sel_e                res_sel;
  logic                                neg_result;
  logic                                neg_rem;
  logic                                div_zero;

  modport iterate (
    output val, pc, seq_num, waddr, raw_hi, raw_lo, res_sel,
    output neg_result, neg_rem, div_zero,
    input  rdy
  );

  modport result (
    input  val, pc, seq_num, waddr, raw_hi, raw_lo, res_sel,
    input  neg_result, neg_rem, div_zero,
    output rdy
  );

endinterface

`default_nettype wire

/* source/muldiv_iterate.sv */
/*
 * Iterative multiply/divide engine
 * Shift-add multiply or restoring divide, one bit per cycle for XLEN
 * cycles, on unsigned magnitudes
 */

`timescale 1ns/1ps
`default_nettype none

module muldiv_iterate #(
  parameter int seq_bits = muldiv_pkg::SEQ_BITS_DEFAULT
) (
  input  logic      clk,
  input  logic      rst_n,
  op_intf.iterate   op,
  res_intf.iterate  res
);

  localparam int XLEN      = muldiv_pkg::XLEN;
  localparam int STEP_BITS = $clog2(XLEN + 1);

  // --------------------
  // State
  // --------------------

  logic                   running;
  logic                   done;
  logic [STEP_BITS-1:0]   step;
  logic                   op_xfer;

  // {hi, lo}: partial product and multiplier, or remainder and quotient
  logic [2*XLEN-1:0]      acc;
  // Multiplicand or divisor
  logic [XLEN-1:0]        operand_b;
  logic                   is_div_r;

  // Tags carried alongside
  logic [XLEN-1:0]        pc_r;
  logic [seq_bits-1:0]    seq_num_r;
  logic [muldiv_pkg::ADDR_BITS-1:0] waddr_r;
  muldiv_pkg::res_sel_e   res_sel_r;
  logic                   neg_result_r;
  logic                   neg_rem_r;
  logic                   div_zero_r;

  // Step datapath
  logic [XLEN:0]          add_sum;
  logic [XLEN:0]          shift_top;
  logic [XLEN:0]          sub_diff;
  logic [2*XLEN-1:0]      acc_next;

  // Idle only
  assign op.rdy  = !running && !done;
  assign op_xfer = op.val && op.rdy;

  // --------------------
  // One step
  // --------------------

  always_comb begin
    // Multiply adds the multiplicand when the current multiplier bit is set
    add_sum   = {1'b0, acc[2*XLEN-1:XLEN]}
              + (acc[0] ? {1'b0, operand_b} : {(XLEN+1){1'b0}});
    // Remainder shifted left with the next dividend bit, 33 bits wide
    shift_top = acc[2*XLEN-1:XLEN-1];
    sub_diff  = shift_top - {1'b0, operand_b};
    if (is_div_r) begin
      if (shift_top >= {1'b0, operand_b}) begin
        acc_next = {sub_diff[XLEN-1:0], acc[XLEN-2:0], 1'b1};
      end else begin
        // Restore, quotient bit 0
        acc_next = {shift_top[XLEN-1:0], acc[XLEN-2:0], 1'b0};
      end
    end else begin
      acc_next = {add_sum, acc[XLEN-1:1]};
    end
  end

  // --------------------
  // Control
  // --------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      running <= 1'b0;
      done    <= 1'b0;
      step    <= '0;
    end else if (op_xfer) begin
      running <= 1'b1;
      step    <= '0;
    end else if (running) begin
      step <= step + 1'b1;
      // Last step
      if (step == STEP_BITS'(XLEN - 1)) begin
        running <= 1'b0;
        done    <= 1'b1;
      end
    end else if (done && res.rdy) begin
      done <= 1'b0;
    end
  end

  // Datapath and tags, no reset
  always_ff @(posedge clk) begin
    if (op_xfer) begin
      acc          <= {{XLEN{1'b0}}, op.mag_a};
      operand_b    <= op.mag_b;
      is_div_r     <= op.is_div;
      pc_r         <= op.pc;
      seq_num_r    <= op.seq_num;
      waddr_r      <= op.waddr;
      res_sel_r    <= op.res_sel;
      neg_result_r <= op.neg_result;
      neg_rem_r    <= op.neg_rem;
      div_zero_r   <= op.div_zero;
    end else if (running) begin
      acc <= acc_next;
    end
  end

  // --------------------
  // Result side
  // --------------------

  assign res.val        = done;
  assign res.raw_hi     = acc[2*XLEN-1:XLEN];
  assign res.raw_lo     = acc[XLEN-1:0];
  assign res.pc         = pc_r;
  assign res.seq_num    = seq_num_r;
  assign res.waddr      = waddr_r;
  assign res.res_sel    = res_sel_r;
  assign res.neg_result = neg_result_r;
  assign res.neg_rem    = neg_rem_r;
  assign res.div_zero   = div_zero_r;

  step_bound_a: assert property (@(posedge clk) disable iff (!rst_n)
    (running || done) |-> step <= STEP_BITS'(XLEN))
    else $error("step counter passed %0d", XLEN);

  // Raw result held while result stage stalls
  raw_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    (res.val && !res.rdy) |=> res.val && $stable(res.raw_hi) && $stable(res.raw_lo))
    else $error("raw result changed under back-pressure");

endmodule

`default_nettype wire

/* source/muldiv_pkg.sv */
/*
 * Multiply/divide execute unit shared definitions
 * Op encoding, datapath width and result word select codes
 */

`default_nettype none

package muldiv_pkg;

  // --------------------
  // Widths
  // --------------------

  // Operand and result width
  localparam int XLEN = 32;

  // Register address width for waddr
  localparam int ADDR_BITS = 5;

  // Sequence number width unless the top level overrides it
  localparam int SEQ_BITS_DEFAULT = 5;

  // --------------------
  // RV32M micro-ops
  // --------------------

  typedef enum logic [2:0] {
    UOP_MUL    = 3'd0,
    UOP_MULH   = 3'd1,
    UOP_MULHSU = 3'd2,
    UOP_MULHU  = 3'd3,
    UOP_DIV    = 3'd4,
    UOP_DIVU   = 3'd5,
    UOP_REM    = 3'd6,
    UOP_REMU   = 3'd7
  } muldiv_uop_e;

  // --------------------
  // Result word select
  // --------------------

  // Which word the result stage writes back
  typedef enum logic [1:0] {
    PROD_LO = 2'd0,
    PROD_HI = 2'd1,
    QUOT    = 2'd2,
    REM     = 2'd3
  } res_sel_e;

endpackage

`default_nettype wire

/* source/muldiv_result.sv */
/*
 * Multiply/divide result stage
 * Sign fix-up, word select and the output register toward W
 */

`timescale 1ns/1ps
`default_nettype none

module muldiv_result #(
  parameter int seq_bits = muldiv_pkg::SEQ_BITS_DEFAULT
) (
  input  logic                              clk,
  input  logic                              rst_n,
  res_intf.result                           res,
  output logic                              w_val,
  output logic [muldiv_pkg::XLEN-1:0]       w_pc,
  output logic [seq_bits-1:0]               w_seq_num,
  output logic [muldiv_pkg::ADDR_BITS-1:0]  w_waddr,
  output logic [muldiv_pkg::XLEN-1:0]       w_wdata,
  output logic                              w_wen,
  input  logic                              w_rdy
);

  localparam int XLEN = muldiv_pkg::XLEN;

  logic [2*XLEN-1:0] prod;
  logic [XLEN-1:0]   quot;
  logic [XLEN-1:0]   rem;
  logic [XLEN-1:0]   wdata_c;
  logic              res_xfer;

  // --------------------
  // Fix-up and select
  // --------------------

  always_comb begin
    prod = res.neg_result ? -{res.raw_hi, res.raw_lo} : {res.raw_hi, res.raw_lo};
    // Divide by zero gives all ones regardless of signs
    quot = res.div_zero ? {XLEN{1'b1}} : (res.neg_result ? -res.raw_lo : res.raw_lo);
    // Also restores the dividend when the divisor is zero
    rem  = res.neg_rem ? -res.raw_hi : res.raw_hi;
    case (res.res_sel)
      muldiv_pkg::PROD_HI: wdata_c = prod[2*XLEN-1:XLEN];
      muldiv_pkg::QUOT:    wdata_c = quot;
      muldiv_pkg::REM:     wdata_c = rem;
      default:             wdata_c = prod[XLEN-1:0];
    endcase
  end

  // --------------------
  // Output register
  // --------------------

  assign res.rdy  = !w_val || w_rdy;
  assign res_xfer = res.val && res.rdy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      w_val <= 1'b0;
    end else if (res_xfer) begin
      w_val <= 1'b1;
    end else if (w_rdy) begin
      w_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (res_xfer) begin
      w_pc      <= res.pc;
      w_seq_num <= res.seq_num;
      w_waddr   <= res.waddr;
      w_wdata   <= wdata_c;
      // x0 is never written
      w_wen     <= (res.waddr != '0);
    end
  end

  w_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    (w_val && !w_rdy) |=> w_val && $stable(w_pc) && $stable(w_seq_num)
      && $stable(w_waddr) && $stable(w_wdata) && $stable(w_wen))
    else $error("W message changed under back-pressure");

endmodule

`default_nettype wire

/* source/muldiv_unit.sv */
/*
 * Iterative RV32M multiply/divide execute unit
 * Decode, 32-step engine and result stage between D and W
 */

`timescale 1ns/1ps
`default_nettype none

module muldiv_unit #(
  parameter int seq_bits = muldiv_pkg::SEQ_BITS_DEFAULT
) (
  input  logic                              clk,
  input  logic                              rst_n,

  // D port
  input  logic                              d_val,
  output logic                              d_rdy,
  input  logic [muldiv_pkg::XLEN-1:0]       d_pc,
  input  logic [seq_bits-1:0]               d_seq_num,
  input  logic [muldiv_pkg::XLEN-1:0]       d_op1,
  input  logic [muldiv_pkg::XLEN-1:0]       d_op2,
  input  logic [muldiv_pkg::ADDR_BITS-1:0]  d_waddr,
  input  muldiv_pkg::muldiv_uop_e           d_uop,

  // W port
  output logic                              w_val,
  input  logic                              w_rdy,
  output logic [muldiv_pkg::XLEN-1:0]       w_pc,
  output logic [seq_bits-1:0]               w_seq_num,
  output logic [muldiv_pkg::ADDR_BITS-1:0]  w_waddr,
  output logic [muldiv_pkg::XLEN-1:0]       w_wdata,
  output logic                              w_wen
);

  // --------------------
  // Stage links
  // --------------------

  op_intf  #(.seq_bits(seq_bits)) op_if ();
  res_intf #(.seq_bits(seq_bits)) res_if ();

  // --------------------
  // Stages
  // --------------------

  muldiv_decode #(.seq_bits(seq_bits)) decode_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .d_val     (d_val),
    .d_pc      (d_pc),
    .d_seq_num (d_seq_num),
    .d_op1     (d_op1),
    .d_op2     (d_op2),
    .d_waddr   (d_waddr),
    .d_uop     (d_uop),
    .d_rdy     (d_rdy),
    .op        (op_if.decode)
  );

  muldiv_iterate #(.seq_bits(seq_bits)) iterate_i (
    .clk   (clk),
    .rst_n (rst_n),
    .op    (op_if.iterate),
    .res   (res_if.iterate)
  );

  muldiv_result #(.seq_bits(seq_bits)) result_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .res       (res_if.result),
    .w_val     (w_val),
    .w_pc      (w_pc),
    .w_seq_num (w_seq_num),
    .w_waddr   (w_waddr),
    .w_wdata   (w_wdata),
    .w_wen     (w_wen),
    .w_rdy     (w_rdy)
  );

endmodule

`default_nettype wire

/* verification/muldiv_checker.sv */
/*
 * Result checker for the multiply/divide unit
 * Compares W messages in order against the expected queue
 */

`timescale 1ns/1ps
`default_nettype none

module muldiv_checker #(
  parameter int seq_bits = muldiv_pkg::SEQ_BITS_DEFAULT
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              d_rdy,
  input  logic                              w_val,
  input  logic                              w_rdy,
  input  logic [muldiv_pkg::XLEN-1:0]       w_pc,
  input  logic [seq_bits-1:0]               w_seq_num,
  input  logic [muldiv_pkg::ADDR_BITS-1:0]  w_waddr,
  input  logic [muldiv_pkg::XLEN-1:0]       w_wdata,
  input  logic                              w_wen,
  input  logic                              exp_push,
  input  logic [127:0]                      exp_name,
  input  logic [muldiv_pkg::XLEN-1:0]       exp_wdata,
  input  logic                              exp_wen,
  input  logic [muldiv_pkg::ADDR_BITS-1:0]  exp_waddr,
  input  logic [muldiv_pkg::XLEN-1:0]       exp_pc,
  input  logic [seq_bits-1:0]               exp_seq,
  output int                                pass_count,
  output int                                fail_count,
  output int                                other_errors,
  output int                                checked
);

  localparam int XLEN = muldiv_pkg::XLEN;
  localparam int MSG_BITS = 2 * XLEN + seq_bits + muldiv_pkg::ADDR_BITS + 1;

  typedef struct packed {
    logic [127:0]                     name;
    logic [XLEN-1:0]                  wdata;
    logic                             wen;
    logic [muldiv_pkg::ADDR_BITS-1:0] waddr;
    logic [XLEN-1:0]                  pc;
    logic [seq_bits-1:0]              seq;
  } expect_t;

  expect_t             exp_q [$];
  expect_t             head;
  logic                bad;
  int                  n_pass = 0;
  int                  n_fail = 0;
  int                  n_other = 0;
  int                  n_checked = 0;
  logic                was_reset = 1'b0;
  logic                stalled = 1'b0;
  logic [MSG_BITS-1:0] held_msg;
  logic [MSG_BITS-1:0] w_msg;

  // Whole W message, for the stall check
  assign w_msg = {w_pc, w_seq_num, w_waddr, w_wdata, w_wen};

  // Prints an error line on a mismatch
  function automatic logic field_mismatch(input logic [127:0] name, input string field,
                                          input logic [31:0] expv, input logic [31:0] actv);
    if (expv !== actv) begin
      $display("** Error %0s %0s: expected %h, actual %h", name, field, expv, actv);
      return 1'b1;
    end
    return 1'b0;
  endfunction

  // --------------------
  // W port monitor
  // --------------------

  always @(posedge clk) begin
    if (!rst_n) begin
      // Output register has seen at least one reset edge
      if (was_reset && w_val !== 1'b0) begin
        $display("w_val was not low during reset");
        n_other++;
      end
    end else begin
      // First cycle out of reset
      if (was_reset && d_rdy !== 1'b1) begin
        $display("d_rdy was not high on the first cycle after reset");
        n_other++;
      end
      if (exp_push) begin
        exp_q.push_back({exp_name, exp_wdata, exp_wen, exp_waddr, exp_pc, exp_seq});
      end
      // Stalled message must not move
      if (stalled && (!w_val || w_msg !== held_msg)) begin
        $display("W message dropped or changed while w_rdy was low");
        n_other++;
      end
      if (w_val && w_rdy) begin
        if (exp_q.size() == 0) begin
          $display("w_val transfer with no test outstanding");
          n_other++;
        end else begin
          head = exp_q.pop_front();
          bad = 1'b0;
          bad |= field_mismatch(head.name, "wdata", head.wdata, w_wdata);
          bad |= field_mismatch(head.name, "wen", 32'(head.wen), 32'(w_wen));
          bad |= field_mismatch(head.name, "waddr", 32'(head.waddr), 32'(w_waddr));
          bad |= field_mismatch(head.name, "pc", head.pc, w_pc);
          bad |= field_mismatch(head.name, "seq_num", 32'(head.seq), 32'(w_seq_num));
          $display("%0s: %s", head.name, bad ? "FAIL" : "PASS");
          if (bad) n_fail++;
          else n_pass++;
          n_checked++;
        end
      end
    end
    stalled      <= rst_n && w_val && !w_rdy;
    held_msg     <= w_msg;
    was_reset    <= !rst_n;
    pass_count   <= n_pass;
    fail_count   <= n_fail;
    other_errors <= n_other;
    checked      <= n_checked;
  end

endmodule

`default_nettype wire

/* verification/muldiv_stimulus.txt */
# name uop(0 MUL 1 MULH 2 MULHSU 3 MULHU 4 DIV 5 DIVU 6 REM 7 REMU) op1 op2 waddr wdata
# all numeric columns in hex
mul_small   0 00000007 00000006 01 0000002a
mul_neg     0 fffffffd 00000005 02 fffffff1
mul_big     0 12345678 00000010 03 23456780
mulh_neg    1 fffffffd 00000005 04 ffffffff
mulh_min    1 80000000 80000000 05 40000000
mulh_pos    1 7fffffff 7fffffff 06 3fffffff
mulhsu_neg  2 ffffffff ffffffff 07 ffffffff
mulhsu_min  2 80000000 80000000 08 c0000000
mulhu_max   3 ffffffff ffffffff 09 fffffffe
mulhu_min   3 80000000 80000000 0a 40000000
mul_min     0 80000000 80000000 0b 00000000
div_pos     4 00000014 00000006 0c 00000003
div_negpos  4 ffffffec 00000006 0d fffffffd
div_posneg  4 00000014 fffffffa 0e fffffffd
div_negneg  4 ffffffec fffffffa 0f 00000003
divu_big    5 ffffffec 00000006 10 2aaaaaa7
rem_negpos  6 ffffffec 00000006 11 fffffffe
rem_posneg  6 00000014 fffffffa 12 00000002
rem_negneg  6 ffffffec fffffffa 13 fffffffe
remu_big    7 ffffffec 00000006 14 00000002
div_zero    4 00001234 00000000 15 ffffffff
divu_zero   5 ffffffec 00000000 16 ffffffff
rem_zero    6 ffffffec 00000000 17 ffffffec
remu_zero   7 00001234 00000000 18 00001234
div_ovf     4 80000000 ffffffff 19 80000000
rem_ovf     6 80000000 ffffffff 1a 00000000
mul_x0      0 00000003 00000003 00 00000009
div_x0      4 00000064 00000007 00 0000000e
mulhu_small 3 00000003 00000004 1b 00000000
remu_small  7 00000064 00000007 1c 00000002
divu_small  5 00000064 00000007 1d 0000000e

/* verification/muldiv_tb.sv */
/*
 * Testbench for the multiply/divide unit
 * Reads tests from the stimulus file, drives D, stalls W at random
 */

`timescale 1ns/1ps
`default_nettype none

module muldiv_tb;

  localparam int SEQ_BITS  = 4;
  localparam int XLEN      = muldiv_pkg::XLEN;
  localparam int ADDR_BITS = muldiv_pkg::ADDR_BITS;

  logic                    clk = 1'b0;
  logic                    rst_n;
  logic                    d_val;
  logic                    d_rdy;
  logic [XLEN-1:0]         d_pc;
  logic [SEQ_BITS-1:0]     d_seq_num;
  logic [XLEN-1:0]         d_op1;
  logic [XLEN-1:0]         d_op2;
  logic [ADDR_BITS-1:0]    d_waddr;
  muldiv_pkg::muldiv_uop_e d_uop;
  logic                    w_val;
  logic                    w_rdy;
  logic [XLEN-1:0]         w_pc;
  logic [SEQ_BITS-1:0]     w_seq_num;
  logic [ADDR_BITS-1:0]    w_waddr;
  logic [XLEN-1:0]         w_wdata;
  logic                    w_wen;

  // Expected message toward the checker
  logic                    exp_push;
  logic [127:0]            exp_name;
  logic [XLEN-1:0]         exp_wdata;
  logic                    exp_wen;
  logic [ADDR_BITS-1:0]    exp_waddr;
  logic [XLEN-1:0]         exp_pc;
  logic [SEQ_BITS-1:0]     exp_seq;
  int                      pass_count;
  int                      fail_count;
  int                      other_errors;
  int                      checked;

  // Test table from the stimulus file
  logic [127:0]            name_q [$];
  logic [2:0]              uop_q [$];
  logic [XLEN-1:0]         op1_q [$];
  logic [XLEN-1:0]         op2_q [$];
  logic [ADDR_BITS-1:0]    waddr_q [$];
  logic [XLEN-1:0]         wdata_q [$];
  int                      num_tests = 0;
  int                      timeout_limit = 100000;
  int                      cycle_count = 0;
  logic                    random_bp;
  logic [SEQ_BITS-1:0]     next_seq;

  always #2 clk = ~clk;

  muldiv_unit #(.seq_bits(SEQ_BITS)) muldiv_unit_i (
    .clk(clk), .rst_n(rst_n),
    .d_val(d_val), .d_rdy(d_rdy), .d_pc(d_pc), .d_seq_num(d_seq_num),
    .d_op1(d_op1), .d_op2(d_op2), .d_waddr(d_waddr), .d_uop(d_uop),
    .w_val(w_val), .w_rdy(w_rdy), .w_pc(w_pc), .w_seq_num(w_seq_num),
    .w_waddr(w_waddr), .w_wdata(w_wdata), .w_wen(w_wen)
  );

  muldiv_checker #(.seq_bits(SEQ_BITS)) checker_i (
    .clk(clk), .rst_n(rst_n), .d_rdy(d_rdy),
    .w_val(w_val), .w_rdy(w_rdy), .w_pc(w_pc), .w_seq_num(w_seq_num),
    .w_waddr(w_waddr), .w_wdata(w_wdata), .w_wen(w_wen),
    .exp_push(exp_push), .exp_name(exp_name), .exp_wdata(exp_wdata), .exp_wen(exp_wen),
    .exp_waddr(exp_waddr), .exp_pc(exp_pc), .exp_seq(exp_seq),
    .pass_count(pass_count), .fail_count(fail_count),
    .other_errors(other_errors), .checked(checked)
  );

  // --------------------
  // W back-pressure and timeout
  // --------------------

  always @(posedge clk) begin
    if (random_bp) w_rdy <= 1'($urandom_range(0, 1));
    else w_rdy <= 1'b1;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("Timeout after %0d cycles, %0d tests never returned a result",
               cycle_count, num_tests - checked);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // Lines that do not parse as six fields are skipped
  task automatic read_stimulus();
    int               fd;
    int               fields;
    logic [8*100-1:0] line;
    logic [127:0]     name;
    logic [2:0]       uop;
    logic [XLEN-1:0]  op1;
    logic [XLEN-1:0]  op2;
    logic [ADDR_BITS-1:0] waddr;
    logic [XLEN-1:0]  wdata;
    fd = $fopen("verification/muldiv_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open verification/muldiv_stimulus.txt");
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        if ($fgets(line, fd) != 0) begin
          fields = $sscanf(line, "%s %h %h %h %h %h", name, uop, op1, op2, waddr, wdata);
          if (fields == 6) begin
            name_q.push_back(name);
            uop_q.push_back(uop);
            op1_q.push_back(op1);
            op2_q.push_back(op2);
            waddr_q.push_back(waddr);
            wdata_q.push_back(wdata);
          end
        end
      end
      $fclose(fd);
    end
    num_tests = name_q.size();
    if (num_tests == 0) $display("No tests were read from the stimulus file");
  endtask

  // Holds the op on D until accepted, then hands the expectation over
  task automatic send_op(input int idx);
    logic            accepted;
    logic [XLEN-1:0] pc;
    pc = 32'h0000_1000 + 32'(idx * 4);
    d_val     <= 1'b1;
    d_pc      <= pc;
    d_seq_num <= next_seq;
    d_op1     <= op1_q[idx];
    d_op2     <= op2_q[idx];
    d_waddr   <= waddr_q[idx];
    d_uop     <= muldiv_pkg::muldiv_uop_e'(uop_q[idx]);
    accepted = 1'b0;
    while (!accepted) begin
      @(posedge clk);
      exp_push <= 1'b0;
      accepted = d_rdy;
    end
    exp_push  <= 1'b1;
    exp_name  <= name_q[idx];
    exp_wdata <= wdata_q[idx];
    // x0 destination never writes
    exp_wen   <= (waddr_q[idx] != '0);
    exp_waddr <= waddr_q[idx];
    exp_pc    <= pc;
    exp_seq   <= next_seq;
    next_seq = next_seq + 1'b1;
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    void'($urandom(28));
    rst_n     = 1'b0;
    d_val     = 1'b0;
    d_pc      = '0;
    d_seq_num = '0;
    d_op1     = '0;
    d_op2     = '0;
    d_waddr   = '0;
    d_uop     = muldiv_pkg::UOP_MUL;
    w_rdy     = 1'b1;
    exp_push  = 1'b0;
    exp_name  = '0;
    exp_wdata = '0;
    exp_wen   = 1'b0;
    exp_waddr = '0;
    exp_pc    = '0;
    exp_seq   = '0;
    random_bp = 1'b0;
    next_seq  = '0;
    read_stimulus();
    // 40 cycles per test, four times over for stalls
    timeout_limit = num_tests * 40 * 4 + 100;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int i = 0; i < num_tests; i++) begin
      // Second half runs with random W stalls
      if (i == num_tests / 2) random_bp <= 1'b1;
      send_op(i);
    end
    d_val <= 1'b0;
    @(posedge clk);
    exp_push <= 1'b0;
    while (checked < num_tests) @(posedge clk);
    // Catch stray results after the last test
    repeat (20) @(posedge clk);
    $display("Tests: %0d passed, %0d failed, %0d other errors",
             pass_count, fail_count, other_errors);
    if (num_tests > 0 && checked == num_tests && fail_count == 0 && other_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
